//--- files.f
design/gpuPkg.sv
design/regAllocator.sv
design/regBank.sv
design/operandCollector.sv
design/regFileTop.sv
bench/regFileTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module regFileTb -f files.f -o regFileSim &&
./obj_dir/regFileSim | tee /dev/stderr | grep -F "Test completed successfully" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- bench/regFileTb.sv
`timescale 1ns/1ns

module regFileTb;
    import gpuPkg::*;

    localparam int DATA_W     = 32;
    localparam int MAX_CYCLES = 2000;  // ~30 operations of under 20 cycles each, wide margin

    logic              clk, rst;
    logic              allocReq, exitReq, wbValid, issueValid, opReady;
    warpIdT            allocWarp, exitWarp, wbWarp, issueWarp;
    logic [2:0]        allocCount;
    regIdT             wbReg, issueSrc1, issueSrc2;
    logic [DATA_W-1:0] wbData, opA, opB;
    logic              busy, issueReady, opValid;
    logic [4:0]        freeCount;

    // reference model of the allocator and the stored registers
    logic [15:0]       slotUsed;
    logic [3:0]        entSlot [8][4];
    logic              entValid [8][4];
    logic [DATA_W-1:0] slotVal [16][2];  // word held in each slot half

    logic [4:0]        expFree;
    logic [DATA_W-1:0] expA, expB;
    int expLat, expBusy, busyLen, sinceAccept;
    int cycles, errCount, errMark, issued, consumed, seed;

    regFileTop #(.DATA_W(DATA_W)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles  <= cycles + 1;
        busyLen <= busy ? busyLen + 1 : 0;  // length of the current busy run
        if (issueValid && issueReady) sinceAccept <= 0;
        else if (sinceAccept < 100) sinceAccept <= sinceAccept + 1;
        if (opValid && opReady) consumed <= consumed + 1;
    end

    task automatic reportError(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errCount++;
    endtask

    assert property (@(posedge clk) $rose(rst) |->
        issueReady && !busy && !opValid && freeCount == 5'd16)
        else reportError("outputs not in their idle state after reset");
    assert property (@(posedge clk) disable iff (!rst) busy |-> !issueReady)
        else reportError("issueReady high while the allocator is busy");
    assert property (@(posedge clk) disable iff (!rst) $fell(busy) |-> busyLen == expBusy)
        else reportError("busy length differs from the expected cycle count");
    assert property (@(posedge clk) disable iff (!rst)
        !busy && !$past(busy) && !allocReq && !exitReq |-> freeCount == expFree)
        else reportError("freeCount differs from the model");
    assert property (@(posedge clk) disable iff (!rst) $rose(opValid) |-> sinceAccept == expLat)
        else reportError("opValid latency after acceptance is wrong");
    assert property (@(posedge clk) disable iff (!rst) opValid |-> opA == expA && opB == expB)
        else reportError("operands differ from the stored register values");
    assert property (@(posedge clk) disable iff (!rst)
        opValid && !opReady |=> opValid && $stable(opA) && $stable(opB))
        else reportError("operand output changed while stalled");
    assert property (@(posedge clk) disable iff (!rst) opValid |-> !issueReady)
        else reportError("issueReady high while a result is held");
    assert property (@(posedge clk) disable iff (!rst) opValid && opReady |=> !opValid)
        else reportError("result still valid after its handshake");

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic allocate(input int w, input int n);
        for (int p = 0; p < n; p++) begin
            for (int s = 15; s >= 0; s--) begin
                if (!slotUsed[s]) entSlot[w][p] = 4'(s);  // ends on the lowest free one
            end
            slotUsed[entSlot[w][p]] = 1'b1;
            entValid[w][p] = 1'b1;
            expFree--;
        end
        expBusy    = n + 1;
        allocReq   = 1'b1;
        allocWarp  = warpIdT'(w);
        allocCount = 3'(n);
        tick();
        allocReq = 1'b0;
        while (busy) tick();
        tick();
    endtask

    task automatic freeWarp(input int w);
        for (int p = 0; p < 4; p++) begin
            if (entValid[w][p]) begin
                slotUsed[entSlot[w][p]] = 1'b0;
                entValid[w][p] = 1'b0;
                expFree++;
            end
        end
        expBusy  = 1;
        exitReq  = 1'b1;
        exitWarp = warpIdT'(w);
        tick();
        exitReq = 1'b0;
        while (busy) tick();
        repeat (2) tick();  // freeCount trails the slot map by one edge
    endtask

    task automatic writeReg(input int w, input int r);
        logic [DATA_W-1:0] v;
        v = $random(seed);
        if (entValid[w][r / 2]) slotVal[entSlot[w][r / 2]][r % 2] = v;
        wbValid = 1'b1;
        wbWarp  = warpIdT'(w);
        wbReg   = regIdT'(r);
        wbData  = v;
        tick();
        wbValid = 1'b0;
    endtask

    // slot s holds row s/2, bank is 2*(s odd) + (reg odd)
    function automatic int bankOf(input int w, input int r);
        return (int'(entSlot[w][r / 2]) % 2) * 2 + r % 2;
    endfunction

    function automatic int rowOf(input int w, input int r);
        return int'(entSlot[w][r / 2]) / 2;
    endfunction

    task automatic readPair(input int w, input int s1, input int s2, input int stall);
        expA   = slotVal[entSlot[w][s1 / 2]][s1 % 2];
        expB   = slotVal[entSlot[w][s2 / 2]][s2 % 2];
        expLat = (bankOf(w, s1) == bankOf(w, s2) && rowOf(w, s1) != rowOf(w, s2)) ? 3 : 2;
        while (!issueReady) tick();
        issueValid = 1'b1;
        issueWarp  = warpIdT'(w);
        issueSrc1  = regIdT'(s1);
        issueSrc2  = regIdT'(s2);
        tick();
        issueValid = 1'b0;
        issued++;
        while (!opValid) tick();
        repeat (stall) tick();
        opReady = 1'b1;
        tick();
        opReady = 1'b0;
    endtask

    task automatic endTest(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errCount - errMark);
        errMark = errCount;
    endtask

    initial begin
        seed       = 47;
        rst        = 1'b0;
        allocReq   = 1'b0;
        allocWarp  = '0;
        allocCount = '0;
        exitReq    = 1'b0;
        exitWarp   = '0;
        wbValid    = 1'b0;
        wbWarp     = '0;
        wbReg      = '0;
        wbData     = '0;
        issueValid = 1'b0;
        issueWarp  = '0;
        issueSrc1  = '0;
        issueSrc2  = '0;
        opReady    = 1'b0;
        slotUsed   = '0;
        expFree    = 5'd16;
        for (int w = 0; w < 8; w++) begin
            for (int p = 0; p < 4; p++) begin
                entValid[w][p] = 1'b0;
                entSlot[w][p]  = '0;
            end
        end
        for (int s = 0; s < 16; s++) begin
            slotVal[s][0] = '0;
            slotVal[s][1] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;
        tick();

        allocate(0, 3);
        allocate(1, 2);
        endTest(1, "allocation timing");

        for (int r = 0; r < 6; r++) writeReg(0, r);
        for (int r = 0; r < 4; r++) writeReg(1, r);
        writeReg(1, 6);  // pair 3 of warp 1 unmapped
        writeReg(2, 0);
        readPair(0, 1, 5, 0);
        readPair(0, 2, 3, 0);
        readPair(1, 0, 3, 0);
        readPair(1, 1, 2, 0);
        endTest(2, "write and read back");

        readPair(0, 0, 4, 0);  // slots 0 and 2 share bank 0
        readPair(0, 0, 1, 0);
        readPair(1, 1, 3, 0);
        endTest(3, "bank conflict latency");

        readPair(0, 3, 3, 0);
        readPair(1, 2, 2, 0);
        endTest(4, "same register");

        readPair(1, 0, 1, 6);
        readPair(0, 4, 5, 3);
        assert (consumed == issued)
            else reportError("results consumed differ from instructions issued");
        endTest(5, "back-pressure");

        freeWarp(0);
        allocate(2, 2);
        allocate(3, 2);
        readPair(2, 1, 2, 0);  // slots 0 and 1 still hold what warp 0 wrote
        readPair(3, 0, 1, 0);  // slot 2 likewise
        for (int r = 0; r < 4; r++) writeReg(2, r);
        writeReg(3, 0);
        writeReg(3, 3);
        writeReg(0, 0);  // warp 0 gone, slot 0 now belongs to warp 2
        readPair(2, 0, 3, 0);
        readPair(2, 1, 2, 0);
        readPair(3, 0, 3, 0);
        endTest(6, "exit and reuse");

        $display("summary: %0d issued, %0d consumed, %0d errors", issued, consumed, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- design/regFileTop.sv
`timescale 1ns/1ns

module regFileTop #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              allocReq,
    input  gpuPkg::warpIdT    allocWarp,
    input  logic [2:0]        allocCount,
    input  logic              exitReq,
    input  gpuPkg::warpIdT    exitWarp,
    output logic              busy,
    output logic [4:0]        freeCount,
    input  logic              wbValid,
    input  gpuPkg::warpIdT    wbWarp,
    input  gpuPkg::regIdT     wbReg,
    input  logic [DATA_W-1:0] wbData,
    input  logic              issueValid,
    output logic              issueReady,
    input  gpuPkg::warpIdT    issueWarp,
    input  gpuPkg::regIdT     issueSrc1,
    input  gpuPkg::regIdT     issueSrc2,
    output logic              opValid,
    input  logic              opReady,
    output logic [DATA_W-1:0] opA,
    output logic [DATA_W-1:0] opB
);
    import gpuPkg::*;

    logic   wbEn;
    bankIdT wbBank;
    rowIdT  wbRow;
    bankIdT src1Bank, src2Bank;
    rowIdT  src1Row, src2Row;

    logic [NUM_BANKS-1:0]        bankRdEn;
    logic [NUM_BANKS*3-1:0]      bankRdRow;
    logic [NUM_BANKS*DATA_W-1:0] bankRdData;

    regAllocator uAlloc (
        .clk(clk), .rst(rst),
        .allocReq(allocReq), .allocWarp(allocWarp), .allocCount(allocCount),
        .exitReq(exitReq), .exitWarp(exitWarp),
        .wbValid(wbValid), .wbWarp(wbWarp), .wbReg(wbReg),
        .issueWarp(issueWarp), .issueSrc1(issueSrc1), .issueSrc2(issueSrc2),
        .busy(busy), .freeCount(freeCount),
        .wbEn(wbEn), .wbBank(wbBank), .wbRow(wbRow),
        .src1Bank(src1Bank), .src2Bank(src2Bank),
        .src1Row(src1Row), .src2Row(src2Row)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : genBank
        regBank #(.DATA_W(DATA_W), .BANK_ID(bankIdT'(b))) uBank (
            .clk(clk),
            .wbEn(wbEn), .wbBank(wbBank), .wbRow(wbRow), .wbData(wbData),
            .rdEn(bankRdEn[b]), .rdRow(bankRdRow[b * 3 +: 3]),
            .rdData(bankRdData[b * DATA_W +: DATA_W])
        );
    end

    operandCollector #(.DATA_W(DATA_W)) uCollector (
        .clk(clk), .rst(rst), .busy(busy),
        .issueValid(issueValid), .issueReady(issueReady),
        .src1Bank(src1Bank), .src2Bank(src2Bank),
        .src1Row(src1Row), .src2Row(src2Row),
        .bankRdEn(bankRdEn), .bankRdRow(bankRdRow), .bankRdData(bankRdData),
        .opValid(opValid), .opReady(opReady), .opA(opA), .opB(opB)
    );

endmodule

//--- design/operandCollector.sv
`timescale 1ns/1ns

module operandCollector #(
    parameter int DATA_W = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                busy,
    input  logic                                issueValid,
    input  gpuPkg::bankIdT                      src1Bank,
    input  gpuPkg::bankIdT                      src2Bank,
    input  gpuPkg::rowIdT                       src1Row,
    input  gpuPkg::rowIdT                       src2Row,
    input  logic [gpuPkg::NUM_BANKS*DATA_W-1:0] bankRdData,
    input  logic                                opReady,
    output logic                                issueReady,
    output logic [gpuPkg::NUM_BANKS-1:0]        bankRdEn,
    output logic [gpuPkg::NUM_BANKS*3-1:0]      bankRdRow,
    output logic                                opValid,
    output logic [DATA_W-1:0]                   opA,
    output logic [DATA_W-1:0]                   opB
);
    import gpuPkg::*;

    colStateT state;
    bankIdT   aBank, bBank;
    rowIdT    aRow, bRow;
    logic     conflict;
    logic     capA, capB;  // data for A/B lands this cycle

    assign issueReady = (state == IDLE) && !busy;
    assign conflict   = (aBank == bBank) && (aRow != bRow);

    always_comb begin
        bankRdEn  = '0;
        bankRdRow = '0;
        if (state == READ1) begin
            bankRdEn[aBank]            = 1'b1;
            bankRdRow[aBank * 3 +: 3]  = aRow;
            if (!conflict) begin  // same entry just repeats A
                bankRdEn[bBank]           = 1'b1;
                bankRdRow[bBank * 3 +: 3] = bRow;
            end
        end else if (state == READ2) begin
            bankRdEn[bBank]           = 1'b1;
            bankRdRow[bBank * 3 +: 3] = bRow;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && issueValid && issueReady) begin
            aBank <= src1Bank;
            bBank <= src2Bank;
            aRow  <= src1Row;
            bRow  <= src2Row;
        end
        if (capA) opA <= bankRdData[aBank * DATA_W +: DATA_W];
        if (capB) opB <= bankRdData[bBank * DATA_W +: DATA_W];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= IDLE;
            capA    <= 1'b0;
            capB    <= 1'b0;
            opValid <= 1'b0;
        end else begin
            capA <= (state == READ1);
            capB <= (state == READ1 && !conflict) || (state == READ2);
            if (capB) opValid <= 1'b1;  // B is always the last capture
            else if (opValid && opReady) opValid <= 1'b0;
            case (state)
                IDLE:  if (issueValid && issueReady) state <= READ1;
                READ1: state <= conflict ? READ2 : HOLD;
                READ2: state <= HOLD;
                HOLD:  if (opValid && opReady) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- design/regBank.sv
`timescale 1ns/1ns

module regBank #(
    parameter int             DATA_W  = 32,
    parameter gpuPkg::bankIdT BANK_ID = '0
) (
    input  logic              clk,
    input  logic              wbEn,
    input  gpuPkg::bankIdT    wbBank,
    input  gpuPkg::rowIdT     wbRow,
    input  logic [DATA_W-1:0] wbData,
    input  logic              rdEn,
    input  gpuPkg::rowIdT     rdRow,
    output logic [DATA_W-1:0] rdData
);
    import gpuPkg::*;

    logic [DATA_W-1:0] mem [BANK_ROWS];
    logic              wrHit;

    assign wrHit = wbEn && (wbBank == BANK_ID);

    always_ff @(posedge clk) begin
        if (wrHit) mem[wbRow] <= wbData;
    end

    // same-cycle read of a written row sees old data
    always_ff @(posedge clk) begin
        if (rdEn) rdData <= mem[rdRow];
    end

endmodule

//--- design/regAllocator.sv
`timescale 1ns/1ns

module regAllocator (
    input  logic            clk,
    input  logic            rst,
    input  logic            allocReq,
    input  gpuPkg::warpIdT  allocWarp,
    input  logic [2:0]      allocCount,
    input  logic            exitReq,
    input  gpuPkg::warpIdT  exitWarp,
    input  logic            wbValid,
    input  gpuPkg::warpIdT  wbWarp,
    input  gpuPkg::regIdT   wbReg,
    input  gpuPkg::warpIdT  issueWarp,
    input  gpuPkg::regIdT   issueSrc1,
    input  gpuPkg::regIdT   issueSrc2,
    output logic            busy,
    output logic [4:0]      freeCount,
    output logic            wbEn,
    output gpuPkg::bankIdT  wbBank,
    output gpuPkg::rowIdT   wbRow,
    output gpuPkg::bankIdT  src1Bank,
    output gpuPkg::bankIdT  src2Bank,
    output gpuPkg::rowIdT   src1Row,
    output gpuPkg::rowIdT   src2Row
);
    import gpuPkg::*;

    localparam int PAIRS       = REGS_PER_WARP / 2;
    localparam int NUM_ENTRIES = NUM_WARPS * PAIRS;
    localparam int ENTRY_W     = $clog2(NUM_ENTRIES);

    allocStateT state, nextState;

    logic [NUM_ENTRIES-1:0] mapValid;
    slotIdT                 mapSlot [NUM_ENTRIES];
    logic [NUM_SLOTS-1:0]   slotMap;  // 1 = slot in use

    warpIdT     warpQ;
    logic [2:0] remaining;
    logic [1:0] pairIdx;

    slotIdT     freeSlot;
    logic       anyFree;
    logic [4:0] freeNow;

    logic [ENTRY_W-1:0] wbEntry, src1Entry, src2Entry;

    // lowest free slot wins
    always_comb begin
        freeSlot = '0;
        anyFree  = 1'b0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!slotMap[i]) begin
                freeSlot = slotIdT'(i);
                anyFree  = 1'b1;
            end
        end
    end

    always_comb begin
        freeNow = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (!slotMap[i]) freeNow = freeNow + 5'd1;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            READY: begin
                if (exitReq) nextState = DEALLO;  // exit has priority
                else if (allocReq) nextState = ALLO;
            end
            ALLO: begin
                if (remaining == 3'd0) nextState = READY;  // one extra cycle to settle count
            end
            DEALLO: nextState = READY;
            default: nextState = READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= READY;
            mapValid  <= '0;
            slotMap   <= '0;
            warpQ     <= '0;
            remaining <= '0;
            pairIdx   <= '0;
            freeCount <= 5'(NUM_SLOTS);
        end else begin
            state     <= nextState;
            freeCount <= freeNow;
            case (state)
                READY: begin
                    if (exitReq) begin
                        warpQ <= exitWarp;
                    end else if (allocReq) begin
                        warpQ     <= allocWarp;
                        remaining <= allocCount;
                        pairIdx   <= '0;
                    end
                end
                ALLO: begin
                    if (remaining != 3'd0) begin
                        remaining <= remaining - 3'd1;
                        pairIdx   <= pairIdx + 2'd1;
                        if (anyFree) begin
                            mapValid[{warpQ, pairIdx}] <= 1'b1;
                            mapSlot[{warpQ, pairIdx}]  <= freeSlot;
                            slotMap[freeSlot]          <= 1'b1;
                        end
                    end
                end
                DEALLO: begin
                    // all four entries of the warp in one go
                    for (int p = 0; p < PAIRS; p++) begin
                        if (mapValid[ENTRY_W'(warpQ * PAIRS + p)]) begin
                            mapValid[ENTRY_W'(warpQ * PAIRS + p)]       <= 1'b0;
                            slotMap[mapSlot[ENTRY_W'(warpQ * PAIRS + p)]] <= 1'b0;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    assign busy = (state != READY);

    assign wbEntry   = {wbWarp, wbReg[2:1]};
    assign src1Entry = {issueWarp, issueSrc1[2:1]};
    assign src2Entry = {issueWarp, issueSrc2[2:1]};

    assign wbEn   = wbValid && mapValid[wbEntry];  // unmapped writes dropped
    assign wbBank = slotBank(mapSlot[wbEntry], wbReg);
    assign wbRow  = slotRow(mapSlot[wbEntry]);

    assign src1Bank = slotBank(mapSlot[src1Entry], issueSrc1);
    assign src1Row  = slotRow(mapSlot[src1Entry]);
    assign src2Bank = slotBank(mapSlot[src2Entry], issueSrc2);
    assign src2Row  = slotRow(mapSlot[src2Entry]);

endmodule

//--- design/gpuPkg.sv
package gpuPkg;

    localparam int NUM_WARPS     = 8;
    localparam int REGS_PER_WARP = 8;  // held as pairs
    localparam int NUM_SLOTS     = 16;
    localparam int NUM_BANKS     = 4;
    localparam int BANK_ROWS     = 8;

    typedef logic [2:0] warpIdT;

    // bits 2..1 pick the pair entry, bit 0 the half
    typedef logic [2:0] regIdT;

    typedef logic [3:0] slotIdT;
    typedef logic [1:0] bankIdT;
    typedef logic [2:0] rowIdT;

    typedef enum logic [1:0] {
        READY,
        ALLO,
        DEALLO
    } allocStateT;

    typedef enum logic [1:0] {
        IDLE,
        READ1,
        READ2,
        HOLD
    } colStateT;

    // slot s sits on row s>>1, bank is {s[0], logical reg bit 0}
    function automatic bankIdT slotBank(slotIdT s, regIdT r);
        return {s[0], r[0]};
    endfunction

    function automatic rowIdT slotRow(slotIdT s);
        return s[3:1];
    endfunction

endpackage
